// File: rv32_serial_core.f
hdl/cpu_mem_pkg.sv
hdl/rv_isa_pkg.sv
hdl/mem_req_if.sv
hdl/fetcher.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/lsu.sv
hdl/execute.sv
hdl/memctrl.sv
hdl/cpu.sv
verif/cpu_assertions.sv
verif/tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the cpu testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
    -f rv32_serial_core.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0

// File: verif/tb_cpu.sv
/* cpu testbench: byte memory model, UART capture, hand-encoded programs and checks */
`timescale 1ns/1ns

module tb_cpu;

    logic        clk_in;
    logic        rst_in;
    logic        rdy_in;
    logic        io_buffer_full;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;
    logic [31:0] dbgreg_dout;

    logic [7:0]  mem [0:131071];
    logic [16:0] rd_addr;
    logic [7:0]  uart_q[$];
    logic [7:0]  exp_q[$];
    logic [31:0] prog[$];
    bit          pressure;
    bit          stop_seen;
    int          test_err;
    int          tests_run;
    int          tests_failed;

    cpu UUT (.*);

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // inputs change on the falling edge, random pauses under pressure
    always @(negedge clk_in) begin
        mem_din <= mem[rd_addr];
        if (pressure) begin
            rdy_in         <= ($urandom % 4) != 0;
            io_buffer_full <= ($urandom % 3) == 0;
        end else begin
            rdy_in         <= 1'b1;
            io_buffer_full <= 1'b0;
        end
    end

    // memory and I/O side of the bus, nothing happens while paused
    always @(posedge clk_in) begin
        if (!rst_in && rdy_in) begin
            rd_addr <= mem_a[16:0];
            if (mem_wr) begin
                if (mem_a[17:16] == 2'b11) begin
                    if (mem_a[2])
                        stop_seen = 1'b1;
                    else
                        uart_q.push_back(mem_dout);
                end else begin
                    mem[mem_a[16:0]] = mem_dout;
                end
            end
        end
    end

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(logic [31:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic compare_value(string name, string what, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("Error: %s %s expected %h actual %h", name, what, exp, act);
            test_err++;
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < 131072; a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 13);
        end
        foreach (prog[k]) begin
            {mem[4*k+3], mem[4*k+2], mem[4*k+1], mem[4*k]} = prog[k];
        end
    endtask

    task automatic apply_reset();
        @(negedge clk_in);
        rst_in = 1'b1;
        repeat (2) @(negedge clk_in);
        rst_in = 1'b0;
    endtask

    // every program ends with a store to the stop address and a self loop
    task automatic run_program(string name, bit check_start);
        int i;
        load_program();
        test_err = 0;
        apply_reset();
        // previous stop store may still be on the bus until reset
        uart_q.delete();
        stop_seen = 1'b0;
        if (check_start) begin
            // first word fetch covers bytes 0 to 3
            for (i = 0; i < 5; i++) begin
                @(negedge clk_in);
                compare_value(name, "mem_wr after reset", 32'd0, 32'(mem_wr));
                assert (mem_a < 32'd4) else begin
                    $display("%s: first bus read is not at address 0 (%h)", name, mem_a);
                    test_err++;
                end
            end
        end
        i = 0;
        while (!stop_seen && i < 20000) begin
            @(negedge clk_in);
            i++;
        end
        if (!stop_seen) begin
            $display("%s: no store to the stop address within %0d cycles", name, i);
            test_err++;
        end
        compare_value(name, "UART byte count", exp_q.size(), uart_q.size());
        foreach (exp_q[k]) begin
            if (k < uart_q.size())
                compare_value(name, $sformatf("UART byte %0d", k), exp_q[k], uart_q[k]);
        end
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_err != 0)
            tests_failed++;
        $display("%s: %s", name, (test_err == 0) ? "ok" : "failed");
    endtask

    task automatic add_stop();
        prog.push_back(s_type(4, 0, 5, 3'd2));
        prog.push_back(j_type(0, 0));
    endtask

    task automatic reset_test();
        prog = {u_type(20'h30, 5, 7'b0110111)};
        add_stop();
        exp_q = {};
        run_program("reset", 1'b1);
        finish_test("reset");
    endtask

    task automatic alu_test(string name);
        prog = {u_type(20'h30, 5, 7'b0110111),
                i_type(100, 0, 3'd0, 1, 7'b0010011),
                i_type(-7, 0, 3'd0, 2, 7'b0010011),
                r_type(7'h00, 2, 1, 3'd0, 3), s_type(0, 3, 5, 3'd0),
                r_type(7'h20, 1, 2, 3'd0, 3), s_type(0, 3, 5, 3'd0),
                i_type(3, 1, 3'd1, 3, 7'b0010011),
                i_type(4, 3, 3'd5, 4, 7'b0010011), s_type(0, 4, 5, 3'd0),
                i_type(32'h401, 2, 3'd5, 3, 7'b0010011), s_type(0, 3, 5, 3'd0),
                r_type(7'h00, 1, 2, 3'd2, 3), s_type(0, 3, 5, 3'd0),
                r_type(7'h00, 1, 2, 3'd3, 3), s_type(0, 3, 5, 3'd0),
                u_type(20'h12345, 6, 7'b0110111),
                i_type(16, 6, 3'd5, 3, 7'b0010011), s_type(0, 3, 5, 3'd0),
                u_type(20'h00001, 10, 7'b0010111),
                i_type(8, 10, 3'd5, 3, 7'b0010011), s_type(0, 3, 5, 3'd0)};
        add_stop();
        // auipc sits at index 19
        exp_q = {8'(100 - 7), 8'(-7 - 100), 8'((100 << 3) >> 4), 8'(-7 >>> 1),
                 8'd1, 8'd0, 8'(32'h12345000 >> 16), 8'((19 * 4 + 32'h1000) >> 8)};
        run_program(name, 1'b0);
        compare_value(name, "a0", 19 * 4 + 32'h1000, dbgreg_dout);
        finish_test(name);
    endtask

    task automatic mem_test(string name);
        prog = {u_type(20'h30, 5, 7'b0110111),
                u_type(20'h00001, 8, 7'b0110111),
                u_type(20'h89ABD, 1, 7'b0110111),
                i_type(-529, 1, 3'd0, 1, 7'b0010011),
                s_type(0, 1, 8, 3'd2),
                i_type(-128, 0, 3'd0, 2, 7'b0010011),
                s_type(5, 2, 8, 3'd0),
                i_type(0, 8, 3'd0, 3, 7'b0000011),
                i_type(24, 3, 3'd5, 4, 7'b0010011), s_type(0, 4, 5, 3'd0),
                i_type(0, 8, 3'd4, 3, 7'b0000011),
                i_type(4, 3, 3'd5, 4, 7'b0010011), s_type(0, 4, 5, 3'd0),
                i_type(0, 8, 3'd2, 3, 7'b0000011),
                i_type(24, 3, 3'd5, 4, 7'b0010011), s_type(0, 4, 5, 3'd0),
                i_type(3, 8, 3'd0, 3, 7'b0000011), s_type(0, 3, 5, 3'd0),
                i_type(5, 8, 3'd4, 3, 7'b0000011), s_type(0, 3, 5, 3'd0),
                i_type(5, 8, 3'd0, 3, 7'b0000011),
                i_type(8, 3, 3'd5, 4, 7'b0010011), s_type(0, 4, 5, 3'd0)};
        add_stop();
        // word 0x89abcdef, byte 0x80 at offset 5
        exp_q = {8'hFF, 8'h0E, 8'h89, 8'h89, 8'h80, 8'hFF};
        run_program(name, 1'b0);
        compare_value(name, "byte 0x1000", 32'hEF, 32'(mem[17'h1000]));
        compare_value(name, "byte 0x1003", 32'h89, 32'(mem[17'h1003]));
        compare_value(name, "byte 0x1005", 32'h80, 32'(mem[17'h1005]));
        finish_test(name);
    endtask

    task automatic branch_test(string name);
        prog = {u_type(20'h30, 5, 7'b0110111),
                i_type(0, 0, 3'd0, 1, 7'b0010011),
                i_type(5, 0, 3'd0, 2, 7'b0010011),
                i_type(1, 1, 3'd0, 1, 7'b0010011),
                b_type(-4, 2, 1, 3'd4),
                s_type(0, 1, 5, 3'd0),
                j_type(8, 6),
                s_type(0, 0, 5, 3'd0),
                s_type(0, 6, 5, 3'd0),
                i_type(56, 0, 3'd0, 7, 7'b0010011),
                i_type(0, 7, 3'd0, 9, 7'b1100111),
                s_type(0, 0, 5, 3'd0), s_type(0, 0, 5, 3'd0), s_type(0, 0, 5, 3'd0),
                s_type(0, 9, 5, 3'd0),
                b_type(8, 2, 1, 3'd1),
                s_type(0, 2, 5, 3'd0),
                b_type(8, 0, 0, 3'd0),
                s_type(0, 0, 5, 3'd0)};
        add_stop();
        // jal at index 6, jalr at index 10
        exp_q = {8'd5, 8'(6 * 4 + 4), 8'(10 * 4 + 4), 8'd5};
        run_program(name, 1'b0);
        finish_test(name);
    endtask

    initial begin
        void'($urandom(90444));
        rst_in = 1'b1;
        rdy_in = 1'b1;
        io_buffer_full = 1'b0;
        mem_din = 8'd0;
        rd_addr = '0;
        pressure = 1'b0;
        stop_seen = 1'b0;
        tests_run = 0;
        tests_failed = 0;

        reset_test();
        alu_test("alu");
        mem_test("load_store");
        branch_test("branch_jump");

        pressure = 1'b1;
        alu_test("alu_pressure");
        mem_test("load_store_pressure");
        branch_test("branch_jump_pressure");
        pressure = 1'b0;
        repeat (2) @(negedge clk_in);

        $display("tests run %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_failed, UUT.u_assertions.fail_count);
        if (tests_failed == 0 && UUT.u_assertions.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verif/cpu_assertions.sv
/* byte bus protocol assertions for cpu, attached with bind */
`timescale 1ns/1ns

module cpu_assertions (
    input logic        clk_in,
    input logic        rst_in,
    input logic        rdy_in,
    input logic        io_buffer_full,
    input logic [7:0]  mem_dout,
    input logic [31:0] mem_a,
    input logic        mem_wr
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    io_write_blocked: assert property (@(posedge clk_in) disable iff (rst_in)
        !(mem_wr && mem_a[17:16] == 2'b11 && io_buffer_full))
        else begin
            $error("I/O write issued while the UART buffer is full");
            fail_count++;
        end

    // mem_wr may still follow io_buffer_full while paused
    bus_frozen: assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |=> $stable(mem_a) && $stable(mem_dout) &&
                    ($stable(mem_wr) || io_buffer_full != $past(io_buffer_full)))
        else begin
            $error("bus outputs changed while rdy_in was low");
            fail_count++;
        end

    reset_idle: assert property (@(posedge clk_in)
        $fell(rst_in) |-> !mem_wr && mem_a == 32'd0)
        else begin
            $error("bus not idle at address 0 after reset");
            fail_count++;
        end

    addr_range: assert property (@(posedge clk_in) mem_a[31:18] == 14'd0)
        else begin
            $error("bus address above the 18-bit range");
            fail_count++;
        end

endmodule

bind cpu cpu_assertions u_assertions (.*);

// File: hdl/cpu.sv
/* RV32I core top level, one instruction in flight over a byte-wide memory bus */
`timescale 1ns/1ns

module cpu import cpu_mem_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    // pause the whole core when low
    input  logic        rdy_in,
    input  logic [7:0]  mem_din,
    output logic [7:0]  mem_dout,
    output logic [31:0] mem_a,
    output logic        mem_wr,
    input  logic        io_buffer_full,
    output logic [31:0] dbgreg_dout
);

    logic        retire;
    logic        fetched;
    logic [31:0] inst;
    addr_t       next_pc;
    addr_t       pc;

    mem_req_if ifetch ();
    mem_req_if dmem ();
    ex_if      ex ();

    fetcher u_fetcher (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .rdy_in  (rdy_in),
        .ifetch  (ifetch),
        .retire  (retire),
        .next_pc (next_pc),
        .fetched (fetched),
        .inst    (inst),
        .pc      (pc)
    );

    decoder u_decoder (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .rdy_in  (rdy_in),
        .fetched (fetched),
        .inst    (inst),
        .pc      (pc),
        .ex      (ex)
    );

    execute u_execute (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .rdy_in      (rdy_in),
        .ex          (ex),
        .dmem        (dmem),
        .retire      (retire),
        .next_pc     (next_pc),
        .dbgreg_dout (dbgreg_dout)
    );

    memctrl u_memctrl (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .rdy_in         (rdy_in),
        .io_buffer_full (io_buffer_full),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .ifetch         (ifetch),
        .dmem           (dmem)
    );

endmodule

// File: hdl/memctrl.sv
/* memory controller, two requesters serialized onto the byte bus with I/O back-pressure */
`timescale 1ns/1ns

module memctrl import cpu_mem_pkg::*; (
    input  logic          clk_in,
    input  logic          rst_in,
    input  logic          rdy_in,
    input  logic          io_buffer_full,
    input  logic [7:0]    mem_din,
    output logic [7:0]    mem_dout,
    output logic [31:0]   mem_a,
    output logic          mem_wr,
    mem_req_if.controller ifetch,
    mem_req_if.controller dmem
);

    logic        busy;
    logic        sel_d;
    logic        wr_q;
    logic [2:0]  cnt;
    acc_len_e    len_q;
    addr_t       base;
    addr_t       bus_addr;
    logic [31:0] wdata_q;
    logic [31:0] data_q;
    logic [31:0] rdata_c;
    logic [1:0]  rd_idx;
    logic        io_block;
    logic        last_step;
    logic        done_c;

    // a cycle with rdy low is invisible to the bus, so outputs just hold
    assign bus_addr = base + addr_t'(cnt);
    assign mem_a    = {14'b0, bus_addr[17:0]};
    assign mem_dout = wdata_q[8*cnt[1:0] +: 8];

    // uart byte waits for room in the buffer
    assign io_block = busy && wr_q && is_io(base) && io_buffer_full;
    assign mem_wr   = busy && wr_q && !io_block;

    // reads run one step longer, data trails the address by a cycle
    assign last_step = wr_q ? (cnt == 3'(len_q)) : (cnt == 3'(len_q) + 3'd1);
    assign done_c    = busy && rdy_in && last_step && !io_block;

    assign dmem.done   = done_c && sel_d;
    assign ifetch.done = done_c && !sel_d;

    // byte arriving now belongs to the previous address
    assign rd_idx = 2'(cnt - 3'd1);

    always_comb begin
        rdata_c = data_q;
        rdata_c[8*rd_idx +: 8] = mem_din;
    end

    assign dmem.rdata   = rdata_c;
    assign ifetch.rdata = rdata_c;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy  <= 1'b0;
            sel_d <= 1'b0;
            wr_q  <= 1'b0;
            cnt   <= 3'd0;
            base  <= '0;
        end else if (rdy_in) begin
            if (!busy) begin
                // data side first
                if (dmem.en || ifetch.en) begin
                    busy  <= 1'b1;
                    sel_d <= dmem.en;
                    wr_q  <= dmem.en ? dmem.wr : ifetch.wr;
                    base  <= dmem.en ? dmem.addr : ifetch.addr;
                    cnt   <= 3'd0;
                end
            end else if (done_c) begin
                busy <= 1'b0;
            end else if (!io_block) begin
                cnt <= cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (!busy) begin
                len_q   <= dmem.en ? dmem.len : ifetch.len;
                wdata_q <= dmem.en ? dmem.wdata : ifetch.wdata;
            end else if (!wr_q && cnt != 3'd0) begin
                data_q <= rdata_c;
            end
        end
    end

endmodule

// File: hdl/execute.sv
/* execute stage: ALU, branch resolution, writeback, next pc, with regfile and lsu */
`timescale 1ns/1ns

module execute import rv_isa_pkg::*, cpu_mem_pkg::*; (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,
    ex_if.sink              ex,
    mem_req_if.requester    dmem,
    output logic            retire,
    output addr_t           next_pc,
    output logic [xlen-1:0] dbgreg_dout
);

    logic [xlen-1:0] rs1_dt, rs2_dt, op_b, alu_res, ld_data, wb_data, rs1_imm;
    logic            use_imm, is_load, is_store, is_mem, is_branch;
    logic            taken, writes_rd, we, finish, done_now;
    addr_t           npc_c;

    assign use_imm   = ex.op inside {alu_addi, alu_slti, alu_sltiu, alu_xori, alu_ori,
                                     alu_andi, alu_slli, alu_srli, alu_srai};
    assign is_load   = ex.op inside {alu_lb, alu_lbu, alu_lw};
    assign is_store  = ex.op inside {alu_sb, alu_sw};
    assign is_mem    = is_load || is_store;
    assign is_branch = ex.op inside {alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu};
    assign writes_rd = !(is_branch || is_store || ex.op == alu_nop);

    assign op_b    = use_imm ? ex.imm : rs2_dt;
    assign rs1_imm = rs1_dt + ex.imm;

    always_comb begin
        case (ex.op)
            alu_sub:             alu_res = rs1_dt - op_b;
            alu_sll, alu_slli:   alu_res = rs1_dt << op_b[4:0];
            alu_slt, alu_slti:   alu_res = {31'b0, $signed(rs1_dt) < $signed(op_b)};
            alu_sltu, alu_sltiu: alu_res = {31'b0, rs1_dt < op_b};
            alu_xor, alu_xori:   alu_res = rs1_dt ^ op_b;
            alu_srl, alu_srli:   alu_res = rs1_dt >> op_b[4:0];
            alu_sra, alu_srai:   alu_res = $signed(rs1_dt) >>> op_b[4:0];
            alu_or, alu_ori:     alu_res = rs1_dt | op_b;
            alu_and, alu_andi:   alu_res = rs1_dt & op_b;
            alu_lui:             alu_res = ex.imm;
            alu_auipc:           alu_res = ex.pc + ex.imm;
            // link address
            alu_jal, alu_jalr:   alu_res = ex.pc + 32'd4;
            default:             alu_res = rs1_dt + op_b;
        endcase
    end

    always_comb begin
        case (ex.op)
            alu_beq:  taken = rs1_dt == rs2_dt;
            alu_bne:  taken = rs1_dt != rs2_dt;
            alu_blt:  taken = $signed(rs1_dt) < $signed(rs2_dt);
            alu_bge:  taken = $signed(rs1_dt) >= $signed(rs2_dt);
            alu_bltu: taken = rs1_dt < rs2_dt;
            alu_bgeu: taken = rs1_dt >= rs2_dt;
            default:  taken = 1'b0;
        endcase
    end

    always_comb begin
        npc_c = ex.pc + 32'd4;
        if (ex.op == alu_jal || taken) begin
            npc_c = ex.pc + ex.imm;
        end else if (ex.op == alu_jalr) begin
            npc_c = rs1_imm & ~32'd1;
        end
    end

    // alu ops finish in the strobe cycle, memory ops when the lsu does
    assign done_now = (ex.en && !is_mem) || finish;
    assign we       = (ex.en && !is_mem && writes_rd) || (finish && is_load);
    assign wb_data  = is_load ? ld_data : alu_res;

    regfile u_regfile (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .rdy_in (rdy_in),
        .rs1    (ex.rs1),
        .rs2    (ex.rs2),
        .rd     (ex.rd),
        .wdata  (wb_data),
        .we     (we),
        .rs1_dt (rs1_dt),
        .rs2_dt (rs2_dt),
        .a0     (dbgreg_dout)
    );

    lsu u_lsu (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .rdy_in    (rdy_in),
        .start     (ex.en && is_mem),
        .store     (is_store),
        .signed_ld (ex.op == alu_lb),
        .len       ((ex.op inside {alu_lw, alu_sw}) ? len_word : len_byte),
        .addr      (rs1_imm),
        .wdata     (rs2_dt),
        .dmem      (dmem),
        .finish    (finish),
        .rdata     (ld_data)
    );

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            retire <= 1'b0;
        end else if (rdy_in) begin
            retire <= done_now;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && done_now) begin
            next_pc <= npc_c;
        end
    end

endmodule

// File: hdl/lsu.sv
/* load/store unit, holds one dmem request and extends loaded bytes */
`timescale 1ns/1ns

module lsu import cpu_mem_pkg::*, rv_isa_pkg::*; (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,
    input  logic            start,
    input  logic            store,
    input  logic            signed_ld,
    input  acc_len_e        len,
    input  addr_t           addr,
    input  logic [xlen-1:0] wdata,
    mem_req_if.requester    dmem,
    output logic            finish,
    output logic [xlen-1:0] rdata
);

    logic req;
    logic sgn_q;

    assign dmem.en = req;
    assign finish  = req && dmem.done;

    // lb sign extends, lbu zero extends
    assign rdata = (dmem.len == len_word) ? dmem.rdata :
                   {{24{sgn_q & dmem.rdata[7]}}, dmem.rdata[7:0]};

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            req <= 1'b0;
        end else if (rdy_in) begin
            if (start) begin
                req <= 1'b1;
            end else if (dmem.done) begin
                req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && start) begin
            dmem.wr    <= store;
            dmem.addr  <= addr;
            dmem.wdata <= wdata;
            dmem.len   <= len;
            sgn_q      <= signed_ld;
        end
    end

endmodule

// File: hdl/regfile.sv
/* 32 x 32 register file, x0 reads zero, a0 debug view */
`timescale 1ns/1ns

module regfile import rv_isa_pkg::*; (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] wdata,
    input  logic            we,
    output logic [xlen-1:0] rs1_dt,
    output logic [xlen-1:0] rs2_dt,
    output logic [xlen-1:0] a0
);

    logic [xlen-1:0] regs [32];

    assign rs1_dt = regs[rs1];
    assign rs2_dt = regs[rs2];
    assign a0     = regs[10];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy_in && we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

// File: hdl/decoder.sv
/* instruction decoder, registered operation, registers and immediate */
`timescale 1ns/1ns

module decoder import rv_isa_pkg::*, cpu_mem_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic        rdy_in,
    input  logic        fetched,
    input  logic [31:0] inst,
    input  addr_t       pc,
    ex_if.source        ex
);

    inst_u           iw;
    alu_op_e         op;
    logic [xlen-1:0] imm;
    logic [2:0]      f3;
    logic            alt;

    assign iw  = inst;
    assign f3  = iw.r.funct3;
    // sub and sra
    assign alt = iw.r.funct7[5];

    always_comb begin
        op  = alu_nop;
        imm = '0;
        case (iw.r.opcode)
            opc_lui: begin
                op  = alu_lui;
                imm = {iw.u.imm, 12'b0};
            end
            opc_auipc: begin
                op  = alu_auipc;
                imm = {iw.u.imm, 12'b0};
            end
            opc_jal: begin
                op  = alu_jal;
                imm = {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12, iw.j.imm11,
                       iw.j.imm10_1, 1'b0};
            end
            opc_jalr: begin
                op  = alu_jalr;
                imm = {{20{iw.i.imm[11]}}, iw.i.imm};
            end
            opc_branch: begin
                imm = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11, iw.b.imm10_5,
                       iw.b.imm4_1, 1'b0};
                case (f3)
                    3'd0: op = alu_beq;
                    3'd1: op = alu_bne;
                    3'd4: op = alu_blt;
                    3'd5: op = alu_bge;
                    3'd6: op = alu_bltu;
                    3'd7: op = alu_bgeu;
                    default: op = alu_nop;
                endcase
            end
            opc_load: begin
                imm = {{20{iw.i.imm[11]}}, iw.i.imm};
                case (f3)
                    3'd0: op = alu_lb;
                    3'd2: op = alu_lw;
                    3'd4: op = alu_lbu;
                    default: op = alu_nop;
                endcase
            end
            opc_store: begin
                imm = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
                case (f3)
                    3'd0: op = alu_sb;
                    3'd2: op = alu_sw;
                    default: op = alu_nop;
                endcase
            end
            opc_imm: begin
                imm = {{20{iw.i.imm[11]}}, iw.i.imm};
                case (f3)
                    3'd0: op = alu_addi;
                    3'd1: op = alu_slli;
                    3'd2: op = alu_slti;
                    3'd3: op = alu_sltiu;
                    3'd4: op = alu_xori;
                    3'd5: op = alt ? alu_srai : alu_srli;
                    3'd6: op = alu_ori;
                    default: op = alu_andi;
                endcase
            end
            opc_reg: begin
                case (f3)
                    3'd0: op = alt ? alu_sub : alu_add;
                    3'd1: op = alu_sll;
                    3'd2: op = alu_slt;
                    3'd3: op = alu_sltu;
                    3'd4: op = alu_xor;
                    3'd5: op = alt ? alu_sra : alu_srl;
                    3'd6: op = alu_or;
                    default: op = alu_and;
                endcase
            end
            default: op = alu_nop;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ex.en <= 1'b0;
        end else if (rdy_in) begin
            ex.en <= fetched;
        end
    end

    // fields stay put until the next fetch
    always_ff @(posedge clk_in) begin
        if (rdy_in && fetched) begin
            ex.op  <= op;
            ex.pc  <= pc;
            ex.imm <= imm;
            ex.rs1 <= iw.r.rs1;
            ex.rs2 <= iw.r.rs2;
            ex.rd  <= iw.r.rd;
        end
    end

endmodule

// File: hdl/fetcher.sv
/* instruction fetch, pc register and one word request per instruction */
`timescale 1ns/1ns

module fetcher import cpu_mem_pkg::*; (
    input  logic         clk_in,
    input  logic         rst_in,
    input  logic         rdy_in,
    mem_req_if.requester ifetch,
    input  logic         retire,
    input  addr_t        next_pc,
    output logic         fetched,
    output logic [31:0]  inst,
    output addr_t        pc
);

    logic req;
    logic wait_ret;

    assign ifetch.en    = req;
    assign ifetch.wr    = 1'b0;
    assign ifetch.addr  = pc;
    assign ifetch.wdata = '0;
    assign ifetch.len   = len_word;

    // word is handed to the decoder in the done cycle
    assign fetched = req && ifetch.done;
    assign inst    = ifetch.rdata;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc       <= '0;
            req      <= 1'b0;
            wait_ret <= 1'b0;
        end else if (rdy_in) begin
            if (req) begin
                if (ifetch.done) begin
                    req      <= 1'b0;
                    wait_ret <= 1'b1;
                end
            end else if (wait_ret) begin
                // one instruction in flight
                if (retire) begin
                    pc       <= next_pc;
                    wait_ret <= 1'b0;
                end
            end else begin
                req <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/mem_req_if.sv
/* mem_req_if: one requester's port to the memory controller
   ex_if: decoded instruction passed from decoder to execute */
`timescale 1ns/1ns

interface mem_req_if import cpu_mem_pkg::*; ();
    logic        en;
    logic        wr;
    addr_t       addr;
    logic [31:0] wdata;
    acc_len_e    len;
    logic        done;
    logic [31:0] rdata;

    // requester keeps every field stable from en until done
    modport requester (output en, wr, addr, wdata, len, input done, rdata);
    modport controller (input en, wr, addr, wdata, len, output done, rdata);
endinterface

interface ex_if import rv_isa_pkg::*, cpu_mem_pkg::*; ();
    logic            en;
    alu_op_e         op;
    addr_t           pc;
    logic [xlen-1:0] imm;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;

    modport source (output en, op, pc, imm, rs1, rs2, rd);
    modport sink (input en, op, pc, imm, rs1, rs2, rd);
endinterface

// File: hdl/rv_isa_pkg.sv
/* RV32I major opcodes, decoded operation enum and the instruction word formats */
package rv_isa_pkg;

    localparam int xlen = 32;

    // major opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;

    typedef enum logic [5:0] {
        alu_nop,
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and,
        alu_addi, alu_slti, alu_sltiu, alu_xori, alu_ori,
        alu_andi, alu_slli, alu_srli, alu_srai,
        alu_lui, alu_auipc, alu_jal, alu_jalr,
        alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
        alu_lb, alu_lbu, alu_lw, alu_sb, alu_sw
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

endpackage

// File: hdl/cpu_mem_pkg.sv
/* address map, I/O addresses, access length and address type */
package cpu_mem_pkg;

    typedef logic [31:0] addr_t;

    // uart output and program stop
    localparam addr_t io_base = 32'h0003_0000;
    localparam addr_t io_stop = 32'h0003_0004;

    // encoded as the index of the last byte
    typedef enum logic [1:0] {
        len_byte = 2'b00,
        len_word = 2'b11
    } acc_len_e;

    // bits 17:16 select the I/O range
    function automatic logic is_io(addr_t a);
        return a[17:16] == io_base[17:16];
    endfunction

endpackage
